// File: pipe_pkg.sv
package pipe_pkg;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    localparam reg_idx_t REG_ZERO = 5'd0;    // x0 reads as zero and never forwards

    // RV32I major opcode field, inst[6:0]
    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_LOAD   = 7'b0000011;    // LB/LH/LW/LBU/LHU
    localparam opcode_t OP_STORE  = 7'b0100011;    // SB/SH/SW
    localparam opcode_t OP_OPIMM  = 7'b0010011;    // ALU with immediate
    localparam opcode_t OP_OP     = 7'b0110011;    // ALU reg-reg, also MUL/DIV
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // Writeback mux source
    typedef logic [2:0] wb_sel_t;

    localparam wb_sel_t WB_ALU  = 3'd0;
    localparam wb_sel_t WB_LOAD = 3'd1;    // Data memory, late in the pipe
    localparam wb_sel_t WB_PC4  = 3'd2;    // Link address for JAL/JALR
    localparam wb_sel_t WB_IMM  = 3'd3;    // LUI
    localparam wb_sel_t WB_MUL  = 3'd4;

    // Instruction memory word address
    typedef logic [11:0] pc_idx_t;

    // What ID knows about its instruction
    typedef struct packed {
        pc_idx_t  pc;
        reg_idx_t rs_a;
        reg_idx_t rs_b;
        opcode_t  opcode;
        logic     is_jump;     // Decoded jump
        logic     is_nop;      // Bubble or real NOP
    } id_info_t;

    // Sources and destination of the instruction in EXE
    typedef struct packed {
        reg_idx_t rs_a;
        reg_idx_t rs_b;
        reg_idx_t rd;
        logic     wr_en;
        wb_sel_t  wb_sel;
        opcode_t  opcode;
    } exe_info_t;

    // Destination only, for MEM and WB
    typedef struct packed {
        reg_idx_t rd;
        logic     wr_en;
        wb_sel_t  wb_sel;
    } dest_info_t;

endpackage

// File: hazard_pkg.sv
package hazard_pkg;

    // Pipeline depth and stage positions inside the per-stage vectors
    localparam int NUM_STAGES = 5;

    localparam int ST_IF  = 0;
    localparam int ST_ID  = 1;
    localparam int ST_EXE = 2;
    localparam int ST_MEM = 3;
    localparam int ST_WB  = 4;

    typedef logic [NUM_STAGES-1:0] stage_vec_t;    // One bit per stage, index by ST_*

    // Flush events from outside the hazard logic
    typedef struct packed {
        logic isr_pc;      // Interrupt controller redirects the PC
        logic isr_pipe;    // Interrupt controller drains the pipe
        logic branch;      // Branch predictor misprediction
        logic jump;        // Jump resolved in ID
    } flush_req_t;

    // Control fanned out to the stage registers
    typedef struct packed {
        stage_vec_t stall;      // Hold stage register
        stage_vec_t flush;      // Clear stage register
        stage_vec_t clk_en;     // Gate stage clock
        logic       rf_clk_en;  // Register file write clock
    } stage_ctrl_t;

    // Forwarding mux selects
    // To ID from EXE, MEM and WB, to EXE from WB only
    typedef struct packed {
        logic exe_to_id_a;
        logic exe_to_id_b;
        logic mem_to_id_a;
        logic mem_to_id_b;
        logic wb_to_id_a;
        logic wb_to_id_b;
        logic wb_to_exe_a;
        logic wb_to_exe_b;
    } fwd_sel_t;

endpackage

// File: forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
    import pipe_pkg::*;
    import hazard_pkg::*;
(
    input  id_info_t   id_info,      // Consumer in ID
    input  exe_info_t  exe_info,     // Producer for ID, consumer for MEM and WB
    input  dest_info_t mem_dest,
    input  dest_info_t wb_dest,
    output fwd_sel_t   fwd_raw,      // Before flush history masking
    output logic       hzd_jalr,     // Load in EXE feeds JALR base in ID
    output logic       hzd_load_use  // Load in MEM feeds EXE
);

    // Operand A use
    // Only the U-type and JAL ignore rs1
    function automatic logic uses_rs_a(input opcode_t op);
        logic used;
        case (op)
            OP_LUI,
            OP_AUIPC,
            OP_JAL:    used = 1'b0;
            default:   used = 1'b1;    // SYSTEM, FENCE and friends carry rs1 too
        endcase
        return used;
    endfunction

    // Operand B use
    // R-type, S-type and B-type only
    function automatic logic uses_rs_b(input opcode_t op);
        logic used;
        case (op)
            OP_OP,
            OP_STORE,
            OP_BRANCH: used = 1'b1;
            default:   used = 1'b0;
        endcase
        return used;
    endfunction

    // Producer writes a register that the consumer reads
    function automatic logic dest_hit(
        input reg_idx_t rd,
        input logic     wr_en,
        input reg_idx_t src,
        input logic     used
    );
        return wr_en && (rd != REG_ZERO) && (rd == src) && used;
    endfunction

    logic id_use_a;
    logic id_use_b;
    logic exe_use_a;
    logic exe_use_b;

    logic exe_hit_a;        // EXE dest vs ID sources
    logic exe_hit_b;
    logic mem_hit_a;        // MEM dest vs ID sources
    logic mem_hit_b;
    logic wb_hit_a;         // WB dest vs ID sources
    logic wb_hit_b;

    logic mem_hit_exe_a;    // MEM dest vs EXE sources
    logic mem_hit_exe_b;
    logic wb_hit_exe_a;     // WB dest vs EXE sources
    logic wb_hit_exe_b;

    logic exe_is_load;
    logic mem_is_load;

    // Operand use per consumer
    assign id_use_a  = uses_rs_a(id_info.opcode);
    assign id_use_b  = uses_rs_b(id_info.opcode);
    assign exe_use_a = uses_rs_a(exe_info.opcode);
    assign exe_use_b = uses_rs_b(exe_info.opcode);

    // Load data is not ready until MEM finishes
    assign exe_is_load = (exe_info.wb_sel == WB_LOAD);
    assign mem_is_load = (mem_dest.wb_sel == WB_LOAD);

    // Raw matches toward ID
    assign exe_hit_a = dest_hit(exe_info.rd, exe_info.wr_en, id_info.rs_a, id_use_a);
    assign exe_hit_b = dest_hit(exe_info.rd, exe_info.wr_en, id_info.rs_b, id_use_b);
    assign mem_hit_a = dest_hit(mem_dest.rd, mem_dest.wr_en, id_info.rs_a, id_use_a);
    assign mem_hit_b = dest_hit(mem_dest.rd, mem_dest.wr_en, id_info.rs_b, id_use_b);
    assign wb_hit_a  = dest_hit(wb_dest.rd, wb_dest.wr_en, id_info.rs_a, id_use_a);
    assign wb_hit_b  = dest_hit(wb_dest.rd, wb_dest.wr_en, id_info.rs_b, id_use_b);

    // Raw matches toward EXE
    assign mem_hit_exe_a = dest_hit(mem_dest.rd, mem_dest.wr_en, exe_info.rs_a, exe_use_a);
    assign mem_hit_exe_b = dest_hit(mem_dest.rd, mem_dest.wr_en, exe_info.rs_b, exe_use_b);
    assign wb_hit_exe_a  = dest_hit(wb_dest.rd, wb_dest.wr_en, exe_info.rs_a, exe_use_a);
    assign wb_hit_exe_b  = dest_hit(wb_dest.rd, wb_dest.wr_en, exe_info.rs_b, exe_use_b);

    // ID selects where the youngest writer wins
    // A load in EXE still shadows MEM and WB since their value is stale
    assign fwd_raw.exe_to_id_a = exe_hit_a && !exe_is_load;
    assign fwd_raw.exe_to_id_b = exe_hit_b && !exe_is_load;
    assign fwd_raw.mem_to_id_a = mem_hit_a && !exe_hit_a;
    assign fwd_raw.mem_to_id_b = mem_hit_b && !exe_hit_b;
    assign fwd_raw.wb_to_id_a  = wb_hit_a && !exe_hit_a && !mem_hit_a;
    assign fwd_raw.wb_to_id_b  = wb_hit_b && !exe_hit_b && !mem_hit_b;

    // EXE selects
    // Any WB write forwards and most of it is late load data
    assign fwd_raw.wb_to_exe_a = wb_hit_exe_a;
    assign fwd_raw.wb_to_exe_b = wb_hit_exe_b;

    // JALR computes its target in ID so a load one ahead must wait a cycle
    assign hzd_jalr = exe_hit_a && exe_is_load && (id_info.opcode == OP_JALR);

    // Load in MEM with its consumer already in EXE
    assign hzd_load_use = mem_is_load && (mem_hit_exe_a || mem_hit_exe_b);

endmodule

// File: sf_controller.sv
`timescale 1ns/1ps

module sf_controller
    import pipe_pkg::*;
    import hazard_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,

    input  pc_idx_t     if_pc,
    input  pc_idx_t     id_pc,
    input  logic        is_jump,       // ID holds a jump
    input  logic        is_nop,        // ID holds a NOP

    input  flush_req_t  flush_req,     // Interrupt, branch and jump flushes
    input  logic        mul_stall,     // Multiplier busy
    input  logic        div_running,   // Divider busy

    input  logic        hzd_jalr,
    input  logic        hzd_load_use,
    input  fwd_sel_t    fwd_raw,
    input  logic        wb_wr_en,      // WB instruction writes the RF

    output stage_ctrl_t ctrl,
    output fwd_sel_t    fwd,
    output logic        load_hazard
);

    // Flush history, one bit per stage
    // Set means the slot now in the next stage was flushed
    logic if_prev;
    logic id_prev;
    logic exe_prev;
    logic mem_prev;
    logic wb_prev;

    stage_vec_t stall;
    stage_vec_t flush;
    stage_vec_t clk_en;

    logic unit_busy;    // Sources shared by the IF, ID and EXE stalls
    logic loop_jump;

    // A flushed slot in MEM cannot produce a real load hazard
    assign load_hazard = hzd_load_use && !mem_prev;

    assign unit_busy = load_hazard || div_running || mul_stall;

    // Stalls
    // JALR hazard holds the front end only and EXE takes a bubble
    assign stall[ST_IF]  = unit_busy || hzd_jalr;
    assign stall[ST_ID]  = unit_busy || hzd_jalr;
    assign stall[ST_EXE] = unit_busy;
    assign stall[ST_MEM] = 1'b0;
    assign stall[ST_WB]  = 1'b0;

    // Jump to itself
    // Refetching the same PC would spin so it is squashed in ID
    assign loop_jump = (if_pc == id_pc) && is_jump && !stall[ST_ID];

    // Flushes act as synchronous clears on the stage registers
    assign flush[ST_IF]  = flush_req.isr_pc;
    assign flush[ST_ID]  = flush_req.isr_pipe || flush_req.jump || flush_req.branch ||
                           loop_jump;
    assign flush[ST_EXE] = hzd_jalr || flush_req.branch || is_nop;
    assign flush[ST_MEM] = unit_busy;    // Bubble behind the held EXE
    assign flush[ST_WB]  = 1'b0;

    // Clock enables
    // Low on own stall or when a flushed slot arrives from upstream
    assign clk_en[ST_IF]  = !(stall[ST_IF] || loop_jump);
    assign clk_en[ST_ID]  = !(stall[ST_ID] || if_prev || loop_jump);
    assign clk_en[ST_EXE] = !(stall[ST_EXE] || id_prev);
    assign clk_en[ST_MEM] = !(flush[ST_MEM] || exe_prev);    // MEM gates on its flush
    assign clk_en[ST_WB]  = !(stall[ST_WB] || mem_prev);

    assign ctrl.stall     = stall;
    assign ctrl.flush     = flush;
    assign ctrl.clk_en    = clk_en;
    assign ctrl.rf_clk_en = wb_wr_en && !wb_prev;    // No RF write from a flushed slot

    // ID selects pass as is
    assign fwd.exe_to_id_a = fwd_raw.exe_to_id_a;
    assign fwd.exe_to_id_b = fwd_raw.exe_to_id_b;
    assign fwd.mem_to_id_a = fwd_raw.mem_to_id_a;
    assign fwd.mem_to_id_b = fwd_raw.mem_to_id_b;
    assign fwd.wb_to_id_a  = fwd_raw.wb_to_id_a;
    assign fwd.wb_to_id_b  = fwd_raw.wb_to_id_b;

    // WB result of a flushed slot is garbage
    assign fwd.wb_to_exe_a = fwd_raw.wb_to_exe_a && !wb_prev;
    assign fwd.wb_to_exe_b = fwd_raw.wb_to_exe_b && !wb_prev;

    // History chain
    // An upstream flushed slot keeps its mark as it moves down
    always_ff @(posedge clk) begin
        if (!nrst) begin
            if_prev  <= 1'b0;
            id_prev  <= 1'b0;
            exe_prev <= 1'b0;
            mem_prev <= 1'b0;
            wb_prev  <= 1'b0;
        end else begin
            if_prev  <= flush[ST_IF];
            id_prev  <= if_prev  || flush[ST_ID];
            exe_prev <= id_prev  || flush[ST_EXE];
            mem_prev <= exe_prev || flush[ST_MEM];
            wb_prev  <= mem_prev || flush[ST_WB];
        end
    end

endmodule

// File: hazard_top.sv
`timescale 1ns/1ps

module hazard_top
    import pipe_pkg::*;
    import hazard_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,

    input  pc_idx_t     if_pc,
    input  id_info_t    id_info,
    input  exe_info_t   exe_info,
    input  dest_info_t  mem_dest,
    input  dest_info_t  wb_dest,

    input  flush_req_t  flush_req,
    input  logic        mul_stall,
    input  logic        div_running,

    output stage_ctrl_t ctrl,
    output fwd_sel_t    fwd,
    output logic        load_hazard
);

    fwd_sel_t fwd_raw;         // Unmasked selects
    logic     hzd_jalr;
    logic     hzd_load_use;

    // Register compares across stages
    forwarding_unit fwd0 (
        .id_info      (id_info),
        .exe_info     (exe_info),
        .mem_dest     (mem_dest),
        .wb_dest      (wb_dest),
        .fwd_raw      (fwd_raw),
        .hzd_jalr     (hzd_jalr),
        .hzd_load_use (hzd_load_use)
    );

    // Stall, flush and clock gating
    sf_controller ctl0 (
        .clk          (clk),
        .nrst         (nrst),
        .if_pc        (if_pc),
        .id_pc        (id_info.pc),
        .is_jump      (id_info.is_jump),
        .is_nop       (id_info.is_nop),
        .flush_req    (flush_req),
        .mul_stall    (mul_stall),
        .div_running  (div_running),
        .hzd_jalr     (hzd_jalr),
        .hzd_load_use (hzd_load_use),
        .fwd_raw      (fwd_raw),
        .wb_wr_en     (wb_dest.wr_en),
        .ctrl         (ctrl),
        .fwd          (fwd),
        .load_hazard  (load_hazard)
    );

endmodule

// File: hazard_asserts.sv
`timescale 1ns/1ps

module hazard_asserts
    import pipe_pkg::*;
    import hazard_pkg::*;
(
    input logic        clk,
    input logic        nrst,
    input pc_idx_t     if_pc,
    input id_info_t    id_info,
    input exe_info_t   exe_info,
    input dest_info_t  mem_dest,
    input dest_info_t  wb_dest,
    input flush_req_t  flush_req,
    input logic        mul_stall,
    input logic        div_running,
    input stage_ctrl_t ctrl,
    input fwd_sel_t    fwd,
    input logic        load_hazard
);

    int fail_count = 0;    // Failed checks

    // rs1 is dead only for U-type and JAL
    function automatic logic reads_a(input opcode_t op);
        return !(op inside {OP_LUI, OP_AUIPC, OP_JAL});
    endfunction

    function automatic logic reads_b(input opcode_t op);
        return op inside {OP_OP, OP_STORE, OP_BRANCH};
    endfunction

    // Real write to a used source with x0 excluded
    function automatic logic feeds(input reg_idx_t rd, input logic wr, input reg_idx_t src,
                                   input logic used);
        return wr && (rd != 5'd0) && (rd == src) && used;
    endfunction

    logic       ea;              // EXE feeds ID operand A
    logic       eb;
    logic       ma;              // MEM feeds ID
    logic       mb;
    logic       wa;              // WB feeds ID
    logic       wb;
    logic       exe_ld;
    logic [5:0] exp_id;          // {exe a, exe b, mem a, mem b, wb a, wb b}
    logic [5:0] act_id;
    logic       exp_load_use;
    logic       exp_jalr;
    logic       busy;            // Stall sources other than JALR

    always_comb begin
        ea = feeds(exe_info.rd, exe_info.wr_en, id_info.rs_a, reads_a(id_info.opcode));
        eb = feeds(exe_info.rd, exe_info.wr_en, id_info.rs_b, reads_b(id_info.opcode));
        ma = feeds(mem_dest.rd, mem_dest.wr_en, id_info.rs_a, reads_a(id_info.opcode));
        mb = feeds(mem_dest.rd, mem_dest.wr_en, id_info.rs_b, reads_b(id_info.opcode));
        wa = feeds(wb_dest.rd, wb_dest.wr_en, id_info.rs_a, reads_a(id_info.opcode));
        wb = feeds(wb_dest.rd, wb_dest.wr_en, id_info.rs_b, reads_b(id_info.opcode));
        exe_ld = (exe_info.wb_sel == WB_LOAD);
        exp_id = {ea && !exe_ld, eb && !exe_ld, ma && !ea, mb && !eb,
                  wa && !ea && !ma, wb && !eb && !mb};    // Youngest writer wins
        act_id = {fwd.exe_to_id_a, fwd.exe_to_id_b, fwd.mem_to_id_a, fwd.mem_to_id_b,
                  fwd.wb_to_id_a, fwd.wb_to_id_b};
        exp_load_use = (mem_dest.wb_sel == WB_LOAD) &&
            (feeds(mem_dest.rd, mem_dest.wr_en, exe_info.rs_a, reads_a(exe_info.opcode)) ||
             feeds(mem_dest.rd, mem_dest.wr_en, exe_info.rs_b, reads_b(exe_info.opcode)));
        exp_jalr = (id_info.opcode == OP_JALR) && exe_ld &&
                   feeds(exe_info.rd, exe_info.wr_en, id_info.rs_a, 1'b1);
        busy = load_hazard || div_running || mul_stall;
    end

    a_fwd_id: assert property (@(posedge clk) disable iff (!nrst) act_id == exp_id)
        else begin
            $error("Mismatch at %0t: fwd ID selects expected %b actual %b", $time,
                   $sampled(exp_id), $sampled(act_id));
            fail_count++;
        end

    a_load_use: assert property (@(posedge clk) disable iff (!nrst)
        exp_load_use && $past(ctrl.flush, 1) == '0 && $past(ctrl.flush, 2) == '0 &&
        $past(ctrl.flush, 3) == '0 && $past(ctrl.flush, 4) == '0 |-> load_hazard)
        else begin
            $error("Load in MEM feeding EXE did not raise load_hazard at %0t", $time);
            fail_count++;
        end

    a_load_ctrl: assert property (@(posedge clk) disable iff (!nrst)
        load_hazard |-> exp_load_use && ctrl.stall[ST_IF] && ctrl.stall[ST_ID] &&
        ctrl.stall[ST_EXE] && ctrl.flush[ST_MEM] && !ctrl.clk_en[ST_MEM])
        else begin
            $error("Load hazard without its cause or its stalls at %0t", $time);
            fail_count++;
        end

    a_jalr: assert property (@(posedge clk) disable iff (!nrst)
        exp_jalr && !busy |-> ctrl.stall[ST_IF] && ctrl.stall[ST_ID] &&
        !ctrl.stall[ST_EXE] && ctrl.flush[ST_EXE])
        else begin
            $error("JALR after a load in EXE not held in IF and ID at %0t", $time);
            fail_count++;
        end

    // Each step down the pipe gates one more enable
    a_chain: assert property (@(posedge clk) disable iff (!nrst)
        !($past(flush_req.isr_pc, 1) && ctrl.clk_en[ST_ID]) &&
        !($past(flush_req.isr_pc, 2) && ctrl.clk_en[ST_EXE]) &&
        !($past(flush_req.isr_pc, 3) && ctrl.clk_en[ST_MEM]) &&
        !($past(flush_req.isr_pc, 4) && ctrl.clk_en[ST_WB]) &&
        !($past(flush_req.isr_pc, 5) &&
          (ctrl.rf_clk_en || fwd.wb_to_exe_a || fwd.wb_to_exe_b)))
        else begin
            $error("Flushed IF slot still enabled a later stage at %0t", $time);
            fail_count++;
        end

    a_loop: assert property (@(posedge clk) disable iff (!nrst)
        if_pc == id_info.pc && id_info.is_jump && !exp_jalr && !busy |->
        ctrl.flush[ST_ID] && !ctrl.clk_en[ST_IF] && !ctrl.clk_en[ST_ID])
        else begin
            $error("Jump to itself not squashed in ID at %0t", $time);
            fail_count++;
        end

    a_branch_nop: assert property (@(posedge clk) disable iff (!nrst)
        (!flush_req.branch || (ctrl.flush[ST_ID] && ctrl.flush[ST_EXE])) &&
        (!id_info.is_nop || ctrl.flush[ST_EXE]))
        else begin
            $error("Branch or NOP flush missing at %0t", $time);
            fail_count++;
        end

    a_unit: assert property (@(posedge clk) disable iff (!nrst)
        div_running || mul_stall |-> ctrl.stall[ST_IF] && ctrl.stall[ST_ID] &&
        ctrl.stall[ST_EXE] && ctrl.flush[ST_MEM])
        else begin
            $error("Busy multiplier or divider did not hold the front end at %0t", $time);
            fail_count++;
        end

endmodule

bind hazard_top hazard_asserts chk0 (
    .clk         (clk),
    .nrst        (nrst),
    .if_pc       (if_pc),
    .id_info     (id_info),
    .exe_info    (exe_info),
    .mem_dest    (mem_dest),
    .wb_dest     (wb_dest),
    .flush_req   (flush_req),
    .mul_stall   (mul_stall),
    .div_running (div_running),
    .ctrl        (ctrl),
    .fwd         (fwd),
    .load_hazard (load_hazard)
);

// File: tb_hazard.sv
`timescale 1ns/1ps

module tb_hazard
    import pipe_pkg::*;
    import hazard_pkg::*;
();

    logic        clk = 1'b0;
    logic        nrst;
    pc_idx_t     if_pc;
    id_info_t    id_info;
    exe_info_t   exe_info;
    dest_info_t  mem_dest;
    dest_info_t  wb_dest;
    flush_req_t  flush_req;
    logic        mul_stall;
    logic        div_running;
    stage_ctrl_t ctrl;
    fwd_sel_t    fwd;
    logic        load_hazard;

    logic [15:0] lfsr = 16'd62605;
    int          errors = 0;       // Value checks in this module
    int          timeouts = 0;
    int          asrt_fails = 0;   // From the bound checker

    hazard_top dut0 (.*);

    always #4 clk = ~clk;    // 8 ns period

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);    // One step per bit
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [7:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    // Roughly one in 32
    function automatic logic rare();
        logic [7:0] v;
        v = rand_bits(5);
        return &v[4:0];
    endfunction

    function automatic opcode_t pick_opcode();
        opcode_t op;
        case (rand_bits(4))
            8'd0, 8'd1: op = OP_LOAD;
            8'd2:       op = OP_STORE;
            8'd3, 8'd4: op = OP_OPIMM;
            8'd5, 8'd6: op = OP_JALR;
            8'd7:       op = OP_BRANCH;
            8'd8:       op = OP_JAL;
            8'd9:       op = OP_LUI;
            8'd10:      op = OP_AUIPC;
            default:    op = OP_OP;
        endcase
        return op;
    endfunction

    // No hazards, no events, LUI uses no sources
    task automatic drive_quiet(input logic wb_wr);
        if_pc           = 12'd1;       // Never equal to the ID PC below
        id_info         = '0;
        id_info.opcode  = OP_LUI;
        exe_info        = '0;
        exe_info.opcode = OP_LUI;
        mem_dest        = '0;
        wb_dest         = '0;
        wb_dest.wr_en   = wb_wr;
        flush_req       = '0;
        mul_stall       = 1'b0;
        div_running     = 1'b0;
    endtask

    task automatic drive_random();
        if_pc            = pc_idx_t'(rand_bits(2));
        id_info.pc       = pc_idx_t'(rand_bits(2));
        id_info.rs_a     = reg_idx_t'(rand_bits(2));    // 0..3 for frequent matches
        id_info.rs_b     = reg_idx_t'(rand_bits(2));
        id_info.opcode   = pick_opcode();
        id_info.is_jump  = rand_bit() & rand_bit();
        id_info.is_nop   = rare();
        exe_info.rs_a    = reg_idx_t'(rand_bits(2));
        exe_info.rs_b    = reg_idx_t'(rand_bits(2));
        exe_info.rd      = reg_idx_t'(rand_bits(2));
        exe_info.wr_en   = rand_bit();
        exe_info.wb_sel  = wb_sel_t'(rand_bits(2));     // ALU, LOAD, PC4 or IMM
        exe_info.opcode  = pick_opcode();
        mem_dest.rd      = reg_idx_t'(rand_bits(2));
        mem_dest.wr_en   = rand_bit();
        mem_dest.wb_sel  = wb_sel_t'(rand_bits(2));
        wb_dest.rd       = reg_idx_t'(rand_bits(2));
        wb_dest.wr_en    = rand_bit();
        wb_dest.wb_sel   = wb_sel_t'(rand_bits(2));
        flush_req.isr_pc   = rare();
        flush_req.isr_pipe = rare();
        flush_req.branch   = rare();
        flush_req.jump     = rare();
        mul_stall        = rare();
        div_running      = rare();
    endtask

    task automatic check_bits(input string name, input logic [4:0] exp, input logic [4:0] act);
        assert (exp === act)
        else begin
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic watched(input int sel);
        logic v;
        case (sel)
            0:       v = load_hazard;
            1:       v = ctrl.stall[ST_ID];
            2:       v = !ctrl.rf_clk_en;
            3:       v = ctrl.flush[ST_ID];
            default: v = ctrl.flush[ST_EXE];
        endcase
        return v;
    endfunction

    // Polls mid cycle, away from both edges
    task automatic wait_for(input string name, input int sel);
        int n;
        n = 0;
        #2;
        while (!watched(sel) && n < 20) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (!watched(sel)) begin
            $display("Timeout waiting for %s at %0t", name, $time);
            timeouts++;
        end
    endtask

    // Quiet cycles drain the flush history
    task automatic settle(input int n);
        @(negedge clk);
        drive_quiet(1'b1);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        nrst = 1'b0;
        drive_quiet(1'b0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        for (int i = 0; i < 2; i++) begin    // Reset state, RF enable follows wr_en
            drive_quiet(i[0]);
            #2;
            check_bits("ctrl.stall", 5'h00, ctrl.stall);
            check_bits("ctrl.flush", 5'h00, ctrl.flush);
            check_bits("ctrl.clk_en", 5'h1F, ctrl.clk_en);
            check_bits("ctrl.rf_clk_en", 5'(wb_dest.wr_en), 5'(ctrl.rf_clk_en));
            @(negedge clk);
        end

        settle(5);
        exe_info.opcode = OP_OP;            // Load in MEM feeding rs2 in EXE
        exe_info.rs_b   = 5'd2;
        mem_dest.rd     = 5'd2;
        mem_dest.wr_en  = 1'b1;
        mem_dest.wb_sel = WB_LOAD;
        wait_for("load_hazard", 0);

        settle(6);
        id_info.opcode  = OP_JALR;          // JALR base from a load in EXE
        id_info.rs_a    = 5'd3;
        exe_info.rd     = 5'd3;
        exe_info.wr_en  = 1'b1;
        exe_info.wb_sel = WB_LOAD;
        exe_info.opcode = OP_LOAD;
        wait_for("JALR stall", 1);

        settle(6);
        exe_info.opcode  = OP_OP;           // WB would forward to EXE rs1
        exe_info.rs_a    = 5'd1;
        wb_dest.rd       = 5'd1;
        flush_req.isr_pc = 1'b1;
        @(negedge clk);
        flush_req.isr_pc = 1'b0;
        wait_for("rf_clk_en low", 2);

        settle(6);
        if_pc           = 12'd7;            // Jump to itself
        id_info.pc      = 12'd7;
        id_info.is_jump = 1'b1;
        wait_for("loop jump flush", 3);

        settle(6);
        flush_req.branch = 1'b1;
        wait_for("branch flush", 4);
        settle(6);
        id_info.is_nop = 1'b1;
        wait_for("NOP flush", 4);
        settle(6);
        div_running = 1'b1;
        wait_for("divider stall", 1);
        settle(6);
        mul_stall = 1'b1;
        wait_for("multiplier stall", 1);

        settle(6);
        repeat (4000) begin
            @(negedge clk);
            drive_random();
        end
        settle(6);

        asrt_fails = dut0.chk0.fail_count;
        $display("Checks done: %0d value errors, %0d assertion failures, %0d timeouts",
                 errors, asrt_fails, timeouts);
        if (errors == 0 && asrt_fails == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: project.f
pipe_pkg.sv
hazard_pkg.sv
forwarding_unit.sv
sf_controller.sv
hazard_top.sv
hazard_asserts.sv
tb_hazard.sv

// File: run.sh
#!/bin/sh
# Compile and run the hazard control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hazard -f project.f -o sim_hazard
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/sim_hazard > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "^Verification passed$" sim.log || exit 1
exit 0
